// File: hw/rv_decode_settings.svh
`ifndef RV_DECODE_SETTINGS_SVH
`define RV_DECODE_SETTINGS_SVH

// Datapath.
`define XLEN       32
`define REG_COUNT  32

//////////////////////////////
// RV32I major opcodes.
//////////////////////////////
`define OPC_LUI        7'b0110111
`define OPC_AUIPC      7'b0010111
`define OPC_JAL        7'b1101111
`define OPC_JALR       7'b1100111
`define OPC_BRANCH     7'b1100011
`define OPC_LOAD       7'b0000011
`define OPC_STORE      7'b0100011
`define OPC_ARLOG_IMM  7'b0010011
`define OPC_ARLOG      7'b0110011
`define OPC_MISC_MEM   7'b0001111
`define OPC_SYSTEM     7'b1110011

`endif

// File: hw/rv_decode_pkg.sv
`include "rv_decode_settings.svh"

package rv_decode_pkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;
	typedef logic [9:0] mod_t; // {funct7, funct3}.

	// One-hot instruction class, all zero when illegal.
	typedef struct packed {
		logic lui;
		logic auipc;
		logic jal;
		logic jalr;
		logic branch;
		logic load;
		logic store;
		logic arlog_imm;
		logic arlog;
		logic misc_mem;
		logic system;
	} inst_class_t;

	typedef struct packed {
		word_t pc;
		word_t inst;
	} fetch_pkt_t;

	typedef struct packed {
		word_t       pc;
		inst_class_t cls;
		logic        illegal;
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		mod_t        mod;
		word_t       imm;
	} decode_pkt_t;

	// To execute.
	typedef struct packed {
		word_t       pc;
		inst_class_t cls;
		logic        illegal;
		reg_idx_t    rd;
		mod_t        mod;
		word_t       op_a;
		word_t       op_b;
		word_t       store_data;
	} issue_pkt_t;

endpackage

// File: hw/inst_fetch_reg.sv
`timescale 1ns/1ps

module inst_fetch_reg
	import rv_decode_pkg::*;
(
	input  logic       clk,
	input  logic       rst,

	input  logic       in_valid,
	input  fetch_pkt_t in_pkt,

	output logic       f_valid,
	output fetch_pkt_t f_pkt
);

	// Strobe delayed by one cycle.
	always_ff @(posedge clk) begin
		if (rst) begin
			f_valid <= 1'b0;
		end else begin
			f_valid <= in_valid;
		end
	end

	// Instruction register.
	always_ff @(posedge clk) begin
		if (in_valid) begin
			f_pkt <= in_pkt;
		end
	end

endmodule

// File: hw/inst_decoder.sv
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module inst_decoder
	import rv_decode_pkg::*;
(
	input  logic        clk,
	input  logic        rst,

	input  logic        f_valid,
	input  fetch_pkt_t  f_pkt,

	output logic        d_valid,
	output decode_pkt_t d_pkt
);

	word_t       ir;
	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;

	logic [11:0] imm_i;
	logic [31:12] imm_u;
	logic [11:0] imm_s;
	logic [12:1] imm_b;
	logic [20:1] imm_j;

	inst_class_t cls;
	mod_t        mod;
	word_t       imm;

	assign ir     = f_pkt.inst;
	assign opcode = ir[6:0];
	assign funct3 = ir[14:12];
	assign funct7 = ir[31:25];

	// Immediate fields.
	assign imm_i = ir[31:20];
	assign imm_u = ir[31:12];
	assign imm_s = {ir[31:25], ir[11:7]};
	assign imm_b = {ir[31], ir[7], ir[30:25], ir[11:8]};
	assign imm_j = {ir[31], ir[19:12], ir[20], ir[30:21]};

	//////////////////////////////
	// Classification.
	//////////////////////////////
	always_comb begin
		cls = '0;
		case (opcode)
			`OPC_LUI:       cls.lui       = 1'b1;
			`OPC_AUIPC:     cls.auipc     = 1'b1;
			`OPC_JAL:       cls.jal       = 1'b1;
			`OPC_JALR:      cls.jalr      = 1'b1;
			`OPC_BRANCH:    cls.branch    = 1'b1;
			`OPC_LOAD:      cls.load      = 1'b1;
			`OPC_STORE:     cls.store     = 1'b1;
			`OPC_ARLOG_IMM: cls.arlog_imm = 1'b1;
			`OPC_ARLOG:     cls.arlog     = 1'b1;
			`OPC_MISC_MEM:  cls.misc_mem  = 1'b1;
			`OPC_SYSTEM:    cls.system    = 1'b1;
			default:        cls           = '0; // Unknown opcode.
		endcase
	end

	// Modifier.
	always_comb begin
		mod      = '0;
		mod[2:0] = funct3;
		if (cls.arlog) begin
			mod[9:3] = funct7;
		end else if (cls.arlog_imm && (funct3 == 3'b001 || funct3 == 3'b101)) begin
			mod[9:3] = funct7; // Shift immediates.
		end
	end

	//////////////////////////////
	// Immediate.
	//////////////////////////////
	always_comb begin
		imm = '0;
		if (cls.lui || cls.auipc) begin
			imm = {imm_u, 12'b0};
		end else if (cls.jal) begin
			imm = {{11{imm_j[20]}}, imm_j, 1'b0};
		end else if (cls.jalr || cls.load || cls.arlog_imm) begin
			imm = {{20{imm_i[11]}}, imm_i};
		end else if (cls.branch) begin
			imm = {{19{imm_b[12]}}, imm_b, 1'b0};
		end else if (cls.store) begin
			imm = {{20{imm_s[11]}}, imm_s};
		end
	end

	//////////////////////////////
	// Output registers.
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			d_valid <= 1'b0;
		end else begin
			d_valid <= f_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (f_valid) begin
			d_pkt.pc      <= f_pkt.pc;
			d_pkt.cls     <= cls;
			d_pkt.illegal <= ~|cls; // Also covers low bits not 11.
			d_pkt.rd      <= ir[11:7];
			d_pkt.rs1     <= ir[19:15];
			d_pkt.rs2     <= ir[24:20];
			d_pkt.mod     <= mod;
			d_pkt.imm     <= imm;
		end
	end

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module reg_file
	import rv_decode_pkg::*;
(
	input  logic     clk,
	input  logic     rst,

	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	output word_t    rdata1,
	output word_t    rdata2,

	input  logic     wb_en,
	input  reg_idx_t wb_rd,
	input  word_t    wb_data
);

	// x0 has no storage.
	word_t regs [1:`REG_COUNT-1];

	function automatic word_t read_port(input reg_idx_t idx);
		word_t val;
		if (idx == '0) begin
			val = '0;
		end else if (wb_en && wb_rd == idx) begin
			val = wb_data; // Write-through.
		end else begin
			val = regs[idx];
		end
		return val;
	endfunction

	always_comb begin
		rdata1 = read_port(rs1);
		rdata2 = read_port(rs2);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

endmodule

// File: hw/operand_stage.sv
`timescale 1ns/1ps

module operand_stage
	import rv_decode_pkg::*;
(
	input  logic        clk,
	input  logic        rst,

	input  logic        d_valid,
	input  decode_pkt_t d_pkt,

	// Register file read side.
	output reg_idx_t    rs1,
	output reg_idx_t    rs2,
	input  word_t       rdata1,
	input  word_t       rdata2,

	output logic        out_valid,
	output issue_pkt_t  out_pkt
);

	word_t op_a;
	word_t op_b;
	logic  use_imm;

	assign rs1 = d_pkt.rs1;
	assign rs2 = d_pkt.rs2;

	//////////////////////////////
	// Operand selection.
	//////////////////////////////
	always_comb begin
		if (d_pkt.cls.auipc || d_pkt.cls.jal) begin
			op_a = d_pkt.pc;
		end else if (d_pkt.cls.lui) begin
			op_a = '0;
		end else begin
			op_a = rdata1;
		end
	end

	assign use_imm = d_pkt.cls.lui | d_pkt.cls.auipc | d_pkt.cls.jal
		| d_pkt.cls.jalr | d_pkt.cls.load | d_pkt.cls.store
		| d_pkt.cls.arlog_imm;

	assign op_b = use_imm ? d_pkt.imm : rdata2;

	//////////////////////////////
	// Issue register.
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= d_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (d_valid) begin
			out_pkt.pc         <= d_pkt.pc;
			out_pkt.cls        <= d_pkt.cls;
			out_pkt.illegal    <= d_pkt.illegal;
			out_pkt.rd         <= d_pkt.rd;
			out_pkt.mod        <= d_pkt.mod;
			out_pkt.op_a       <= op_a;
			out_pkt.op_b       <= op_b;
			out_pkt.store_data <= rdata2;
		end
	end

endmodule

// File: hw/decode_pipe.sv
`timescale 1ns/1ps

module decode_pipe
	import rv_decode_pkg::*;
(
	input  logic       clk,
	input  logic       rst,

	input  logic       in_valid,
	input  fetch_pkt_t in_pkt,

	// Write-back.
	input  logic       wb_en,
	input  reg_idx_t   wb_rd,
	input  word_t      wb_data,

	output logic       out_valid,
	output issue_pkt_t out_pkt
);

	logic        f_valid;
	fetch_pkt_t  f_pkt;
	logic        d_valid;
	decode_pkt_t d_pkt;
	reg_idx_t    rs1;
	reg_idx_t    rs2;
	word_t       rdata1;
	word_t       rdata2;

	inst_fetch_reg u_fetch_reg (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_pkt   (in_pkt),
		.f_valid  (f_valid),
		.f_pkt    (f_pkt)
	);

	inst_decoder u_decoder (
		.clk     (clk),
		.rst     (rst),
		.f_valid (f_valid),
		.f_pkt   (f_pkt),
		.d_valid (d_valid),
		.d_pkt   (d_pkt)
	);

	reg_file u_reg_file (
		.clk     (clk),
		.rst     (rst),
		.rs1     (rs1),
		.rs2     (rs2),
		.rdata1  (rdata1),
		.rdata2  (rdata2),
		.wb_en   (wb_en),
		.wb_rd   (wb_rd),
		.wb_data (wb_data)
	);

	operand_stage u_operand (
		.clk       (clk),
		.rst       (rst),
		.d_valid   (d_valid),
		.d_pkt     (d_pkt),
		.rs1       (rs1),
		.rs2       (rs2),
		.rdata1    (rdata1),
		.rdata2    (rdata2),
		.out_valid (out_valid),
		.out_pkt   (out_pkt)
	);

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst
);

	// 10 ns period.
	initial begin
		clk = 1'b0;
	end

	always #5 clk = ~clk;

	// Reset held for three rising edges.
	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// File: bench/tb_decode_pipe.sv
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module tb_decode_pipe
	import rv_decode_pkg::*;
;

	localparam int WB_WRITES  = 16;
	localparam int N_ISOLATED = 12;
	localparam int N_BURSTS   = 8;
	localparam int BURST_LEN  = 50;
	localparam int N_WT       = 8;
	localparam int STIM_CYCLES = 8 + (WB_WRITES + 1) + N_ISOLATED * 7
		+ N_BURSTS * (BURST_LEN + WB_WRITES + 7) + N_WT * 9 + 8;
	localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

	logic       clk;
	logic       rst;
	logic       in_valid;
	fetch_pkt_t in_pkt;
	logic       wb_en;
	reg_idx_t   wb_rd;
	word_t      wb_data;
	logic       out_valid;
	issue_pkt_t out_pkt;

	word_t      lcg_state = 32'he174_9adb;
	word_t      shadow [0:31];
	word_t      next_pc;
	int         cyc = 0;
	issue_pkt_t exp_q [$];
	int         due_q [$];

	tb_clock u_tb_clock (
		.clk (clk),
		.rst (rst)
	);

	decode_pipe u_decode_pipe (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_pkt    (in_pkt),
		.wb_en     (wb_en),
		.wb_rd     (wb_rd),
		.wb_data   (wb_data),
		.out_valid (out_valid),
		.out_pkt   (out_pkt)
	);

	//////////////////////////////
	// Checks
	//////////////////////////////
	task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("error %s expected 0x%08h actual 0x%08h", name, exp, act);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			$display("%s", what);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	function automatic word_t rand32();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	//////////////////////////////
	// Reference model
	//////////////////////////////
	function automatic logic [6:0] opcode_of(input int sel);
		case (sel)
			0:       return `OPC_LUI;
			1:       return `OPC_AUIPC;
			2:       return `OPC_JAL;
			3:       return `OPC_JALR;
			4:       return `OPC_BRANCH;
			5:       return `OPC_LOAD;
			6:       return `OPC_STORE;
			7:       return `OPC_ARLOG_IMM;
			8:       return `OPC_ARLOG;
			9:       return `OPC_MISC_MEM;
			10:      return `OPC_SYSTEM;
			default: return 7'b0110001; // Low bits 01, not a 32-bit opcode.
		endcase
	endfunction

	function automatic inst_class_t ref_class(input word_t w);
		inst_class_t c;
		c.lui       = (w[6:0] == `OPC_LUI);
		c.auipc     = (w[6:0] == `OPC_AUIPC);
		c.jal       = (w[6:0] == `OPC_JAL);
		c.jalr      = (w[6:0] == `OPC_JALR);
		c.branch    = (w[6:0] == `OPC_BRANCH);
		c.load      = (w[6:0] == `OPC_LOAD);
		c.store     = (w[6:0] == `OPC_STORE);
		c.arlog_imm = (w[6:0] == `OPC_ARLOG_IMM);
		c.arlog     = (w[6:0] == `OPC_ARLOG);
		c.misc_mem  = (w[6:0] == `OPC_MISC_MEM);
		c.system    = (w[6:0] == `OPC_SYSTEM);
		return c;
	endfunction

	function automatic mod_t ref_mod(input word_t w, input inst_class_t c);
		mod_t m;
		m = {7'b0, w[14:12]};
		// Shift immediates are funct3 x01.
		if (c.arlog || (c.arlog_imm && w[13:12] == 2'b01)) begin
			m[9:3] = w[31:25];
		end
		return m;
	endfunction

	function automatic word_t ref_imm(input word_t w, input inst_class_t c);
		word_t i_imm;
		word_t res;
		i_imm = $signed(w) >>> 20;
		if (c.lui || c.auipc) begin
			res = {w[31:12], 12'h000};
		end else if (c.jal) begin
			res = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		end else if (c.jalr || c.load || c.arlog_imm) begin
			res = i_imm;
		end else if (c.branch) begin
			res = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		end else if (c.store) begin
			res = {i_imm[31:5], w[11:7]};
		end else begin
			res = '0;
		end
		return res;
	endfunction

	function automatic issue_pkt_t ref_issue(input word_t pc, input word_t w);
		issue_pkt_t  p;
		inst_class_t c;
		word_t       r1;
		word_t       r2;
		c  = ref_class(w);
		r1 = shadow[w[19:15]];
		r2 = shadow[w[24:20]];
		p.pc      = pc;
		p.cls     = c;
		p.illegal = (c == '0);
		p.rd      = w[11:7];
		p.mod     = ref_mod(w, c);
		if (c.auipc || c.jal) begin
			p.op_a = pc;
		end else if (c.lui) begin
			p.op_a = '0;
		end else begin
			p.op_a = r1;
		end
		// Register operand only for reg-reg, misc, system and unknown words.
		if (c.branch || c.arlog || c.misc_mem || c.system || c == '0) begin
			p.op_b = r2;
		end else begin
			p.op_b = ref_imm(w, c);
		end
		p.store_data = r2;
		return p;
	endfunction

	//////////////////////////////
	// Stimulus tasks
	//////////////////////////////
	task automatic send_item(input word_t w);
		fetch_pkt_t f;
		f.pc   = next_pc;
		f.inst = w;
		@(posedge clk);
		in_valid <= 1'b1;
		in_pkt   <= f;
		exp_q.push_back(ref_issue(next_pc, w));
		due_q.push_back(cyc + 4); // Seen at the negedge after the third edge.
		next_pc = next_pc + 32'd4;
	endtask

	task automatic end_items();
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
	endtask

	task automatic writeback_phase(input int n);
		word_t r;
		word_t data;
		for (int k = 0; k < n; k++) begin
			r    = rand32();
			data = rand32();
			if (k == 0) begin
				r[31:27] = 5'd0; // x0 must ignore this.
			end
			@(posedge clk);
			wb_en   <= 1'b1;
			wb_rd   <= r[31:27];
			wb_data <= data;
			if (r[31:27] != 5'd0) begin
				shadow[r[31:27]] = data;
			end
		end
		@(posedge clk);
		wb_en <= 1'b0;
	endtask

	// Write lands on the same edge as the stage 3 read of rs1.
	task automatic send_with_writethrough(input word_t w, input word_t data);
		reg_idx_t tgt;
		tgt = w[19:15];
		shadow[tgt] = data;
		send_item(w);
		end_items();
		@(posedge clk);
		wb_en   <= 1'b1;
		wb_rd   <= tgt;
		wb_data <= data;
		@(posedge clk);
		wb_en <= 1'b0;
	endtask

	//////////////////////////////
	// Monitor and timeout
	//////////////////////////////
	always @(posedge clk) begin
		cyc <= cyc + 1;
		check_true(cyc < TIMEOUT_CYCLES, "Run did not finish within the cycle limit");
	end

	always @(negedge clk) begin
		issue_pkt_t exp;
		int         due;
		if (!rst) begin
			if (out_valid) begin
				check_true(exp_q.size() != 0, "out_valid went high with no item in flight");
				exp = exp_q.pop_front();
				due = due_q.pop_front();
				check_field("out_valid cycle", due, cyc);
				check_field("pc", exp.pc, out_pkt.pc);
				check_field("cls", {21'd0, exp.cls}, {21'd0, out_pkt.cls});
				check_field("illegal", {31'd0, exp.illegal}, {31'd0, out_pkt.illegal});
				check_field("rd", {27'd0, exp.rd}, {27'd0, out_pkt.rd});
				check_field("mod", {22'd0, exp.mod}, {22'd0, out_pkt.mod});
				check_field("op_a", exp.op_a, out_pkt.op_a);
				check_field("op_b", exp.op_b, out_pkt.op_b);
				check_field("store_data", exp.store_data, out_pkt.store_data);
			end else if (due_q.size() != 0) begin
				check_true(due_q[0] > cyc, "out_valid missing for an item that was due");
			end
		end
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////
	initial begin
		word_t w;
		word_t r;
		word_t s;
		in_valid <= 1'b0;
		in_pkt   <= '0;
		wb_en    <= 1'b0;
		wb_rd    <= '0;
		wb_data  <= '0;
		next_pc  = 32'h0000_1000;
		for (int i = 0; i < 32; i++) begin
			shadow[i] = '0;
		end

		@(posedge clk);
		while (rst) begin
			@(posedge clk);
		end
		repeat (2) @(posedge clk);

		writeback_phase(WB_WRITES);

		// One isolated item per opcode choice.
		for (int i = 0; i < N_ISOLATED; i++) begin
			r = rand32();
			w = {r[31:7], opcode_of(i)};
			if (i % 2 == 0) begin
				w[19:15] = 5'd0;
			end
			send_item(w);
			end_items();
			wait_drain();
		end

		for (int b = 0; b < N_BURSTS; b++) begin
			for (int k = 0; k < BURST_LEN; k++) begin
				r = rand32();
				s = rand32();
				w = {r[31:7], opcode_of(int'(s[31:16] % 16'd12))};
				send_item(w);
			end
			end_items();
			wait_drain();
			writeback_phase(WB_WRITES);
		end

		for (int t = 0; t < N_WT; t++) begin
			r = rand32();
			w = {r[31:7], `OPC_ARLOG};
			w[19:15] = 5'd1 + 5'(r[31:24] % 8'd31); // Never x0.
			send_with_writethrough(w, rand32());
			wait_drain();
		end

		repeat (8) @(posedge clk);
		if (exp_q.size() == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			$display("%0d items never reached the output", exp_q.size());
			$display("Test FAILED");
			$fatal(1);
		end
	end

endmodule

// File: tb.f
+incdir+hw
hw/rv_decode_pkg.sv
hw/inst_fetch_reg.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/operand_stage.sv
hw/decode_pipe.sv
bench/tb_clock.sv
bench/tb_decode_pipe.sv

// File: run.sh
#!/usr/bin/env bash
# Compile the decode pipeline testbench with Verilator and run it.
# The exit status of the simulation is the pass or fail result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f tb.f \
	--top-module tb_decode_pipe \
	-o sim_decode_pipe

./obj_dir/sim_decode_pipe
